/* source/fp_defines.svh */
// Format and pipeline constants for the floating-point multiplier
// IEEE single precision widths, operation codes and latency
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Single precision fields
`define FP_EXP_WIDTH 8
`define FP_FRAC_WIDTH 23
`define FP_BIAS 127

// Signed exponent wide enough for sums of two biased exponents
`define FP_WIDE_EXP_WIDTH 10

// Multiplier datapath wide enough for a full integer magnitude
`define FP_SIG_WIDTH 32
`define FP_PRODUCT_WIDTH 64
// Weight-one bit of the product of two 24-bit significands
`define FP_PRODUCT_POINT 46

// Operation codes
`define FMUL_OP_WIDTH 6
`define FMUL_OP_FMUL 6'b100010
`define FMUL_OP_ITOF 6'b101010

`define FMUL_LATENCY 3

`endif

/* source/fp_format_pkg.sv */
// Number format types for the floating-point multiplier
// IEEE single-precision word and the wide intermediate quantities
`default_nettype none

`include "fp_defines.svh"

package fp_format_pkg;

	// Raw 32-bit operand holding a float or a signed integer
	typedef logic [31:0] word_t;

	// Biased exponent field
	typedef logic [`FP_EXP_WIDTH-1:0] exponent_t;

	// Stored fraction without the hidden one
	typedef logic [`FP_FRAC_WIDTH-1:0] fraction_t;

	// One single-precision number with the sign as msb
	typedef struct packed {
		logic sign;
		exponent_t exponent;
		fraction_t fraction;
	} float_t;

	// Signed exponent before saturation so underflow shows as negative
	typedef logic signed [`FP_WIDE_EXP_WIDTH-1:0] wide_exponent_t;

	// Multiplier operands and full product
	typedef logic [`FP_SIG_WIDTH-1:0] significand_t;
	typedef logic [`FP_PRODUCT_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

/* source/fmul_pipe_pkg.sv */
// Pipeline types for the floating-point multiplier
// Operation codes, request word and the stage-to-stage registers
`default_nettype none

`include "fp_defines.svh"

package fmul_pipe_pkg;

	import fp_format_pkg::*;

	// Supported operations
	typedef enum logic [`FMUL_OP_WIDTH-1:0] {
		FMUL_OP_FMUL = `FMUL_OP_FMUL,
		FMUL_OP_ITOF = `FMUL_OP_ITOF
	} fmul_op_e;

	// One request from the issuing side per valid cycle
	typedef struct packed {
		logic valid;
		fmul_op_e op;
		word_t a;
		word_t b;
	} fmul_req_t;

	// Stage 1 to stage 2
	// Exponent already carries the product scaling of the significands
	typedef struct packed {
		logic valid;
		logic sign;
		logic zero;
		wide_exponent_t exponent;
		significand_t significand1;
		significand_t significand2;
	} fmul_s1_t;

	// Stage 2 to stage 3
	typedef struct packed {
		logic valid;
		logic sign;
		logic zero;
		wide_exponent_t exponent;
		product_t product;
	} fmul_s2_t;

endpackage

`default_nettype wire

/* source/fp_multiplier_stage1.sv */
// Floating-point multiplier, stage 1
// Unpacks the operands, forms sign and exponent sum, detects zero
// and prepares the integer magnitude for integer-to-float
`timescale 1ns/1ps
`default_nettype none

`include "fp_defines.svh"

module fp_multiplier_stage1
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n_i,
	input wire fmul_req_t req_i,
	output fmul_s1_t s1_o
);

	float_t fa;
	float_t fb;
	word_t int_mag;
	fmul_s1_t s1_next;

	// Operands seen as floats
	assign fa = req_i.a;
	assign fb = req_i.b;

	// Two's-complement magnitude of the integer operand
	// 32'h80000000 maps onto itself as the unsigned value 2^31
	assign int_mag = req_i.a[31] ? (~req_i.a + word_t'(1)) : req_i.a;

	always_comb
	begin
		s1_next.valid = req_i.valid;
		if (req_i.op == FMUL_OP_ITOF)
		begin
			// Integer times one sits in the product at weight one
			s1_next.sign = req_i.a[31];
			s1_next.zero = (req_i.a == '0);
			s1_next.exponent = wide_exponent_t'(`FP_BIAS + `FP_PRODUCT_POINT);
			s1_next.significand1 = int_mag;
			s1_next.significand2 = significand_t'(1);
		end
		else
		begin
			s1_next.sign = fa.sign ^ fb.sign;
			// Only an all-zero magnitude counts as zero
			s1_next.zero = ({fa.exponent, fa.fraction} == '0) ||
				({fb.exponent, fb.fraction} == '0);
			// Remove one bias from the sum of the biased exponents
			s1_next.exponent = wide_exponent_t'(fa.exponent) +
				wide_exponent_t'(fb.exponent) - wide_exponent_t'(`FP_BIAS);
			// Restore the hidden ones
			s1_next.significand1 = significand_t'({1'b1, fa.fraction});
			s1_next.significand2 = significand_t'({1'b1, fb.fraction});
		end

		// Zero second significand forces a zero product downstream
		if (s1_next.zero)
			s1_next.significand2 = '0;
	end

	// Only the valid bit is cleared on reset
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			s1_o.valid <= 1'b0;
		else
			s1_o <= s1_next;
	end

endmodule

`default_nettype wire

/* source/fp_multiplier_stage2.sv */
// Floating-point multiplier, stage 2
// Registered full-width significand multiply, maps to a DSP block
`timescale 1ns/1ps
`default_nettype none

module fp_multiplier_stage2
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n_i,
	input wire fmul_s1_t s1_i,
	output fmul_s2_t s2_o
);

	fmul_s2_t s2_next;

	always_comb
	begin
		// Side information rides along unchanged
		s2_next.valid = s1_i.valid;
		s2_next.sign = s1_i.sign;
		s2_next.zero = s1_i.zero;
		s2_next.exponent = s1_i.exponent;
		// Full 64-bit product with no bits dropped
		s2_next.product = product_t'(s1_i.significand1) * product_t'(s1_i.significand2);
	end

	// Only the valid bit is cleared on reset
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			s2_o.valid <= 1'b0;
		else
			s2_o <= s2_next;
	end

endmodule

`default_nettype wire

/* source/fp_multiplier_stage3.sv */
// Floating-point multiplier, stage 3
// Normalizes the product on its leading one, truncates,
// saturates on exponent overflow or underflow and packs the result
`timescale 1ns/1ps
`default_nettype none

`include "fp_defines.svh"

module fp_multiplier_stage3
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n_i,
	input wire fmul_s2_t s2_i,
	output logic res_valid_o,
	output float_t res_o
);

	logic [5:0] lead_pos;
	logic [5:0] lead_zeros;
	product_t norm_product;
	wide_exponent_t res_exp;
	float_t res_next;

	// Position of the highest set bit as the last hit of the scan
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < `FP_PRODUCT_WIDTH; i++)
		begin
			if (s2_i.product[i])
				lead_pos = 6'(i);
		end
	end

	assign lead_zeros = 6'(`FP_PRODUCT_WIDTH - 1) - lead_pos;

	// Leading one moves to the msb with the fraction just below it
	// Short products get zero fill at the bottom automatically
	assign norm_product = s2_i.product << lead_zeros;

	// Scale by the distance of the leading one from the product point
	assign res_exp = s2_i.exponent + wide_exponent_t'(lead_pos) -
		wide_exponent_t'(`FP_PRODUCT_POINT);

	always_comb
	begin
		res_next.sign = s2_i.sign;
		if (s2_i.zero)
		begin
			res_next.exponent = '0;
			res_next.fraction = '0;
		end
		else if (res_exp >= wide_exponent_t'({`FP_EXP_WIDTH{1'b1}}))
		begin
			// Overflow to signed infinity
			res_next.exponent = '1;
			res_next.fraction = '0;
		end
		else if (res_exp <= wide_exponent_t'(0))
		begin
			// Underflow flushes to signed zero
			res_next.exponent = '0;
			res_next.fraction = '0;
		end
		else
		begin
			// Truncation drops the bits below the fraction
			res_next.exponent = res_exp[`FP_EXP_WIDTH-1:0];
			res_next.fraction = norm_product[`FP_PRODUCT_WIDTH-2 -: `FP_FRAC_WIDTH];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= s2_i.valid;
	end

	// Result word qualified by res_valid_o
	always_ff @(posedge clk)
	begin
		res_o <= res_next;
	end

endmodule

`default_nettype wire

/* source/fp_multiplier.sv */
// Pipelined single-precision multiplier with integer-to-float
// Three stages, one operation per cycle, fixed three-cycle latency
`timescale 1ns/1ps
`default_nettype none

module fp_multiplier
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n_i,
	input wire fmul_req_t req_i,
	output logic res_valid_o,
	output float_t res_o
);

	// Stage registers with valid travelling inside
	fmul_s1_t s1;
	fmul_s2_t s2;

	// Unpack, sign, exponent sum, zero detect
	fp_multiplier_stage1 stage1 (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.req_i(req_i),
		.s1_o(s1)
	);

	// Significand multiply
	fp_multiplier_stage2 stage2 (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.s1_i(s1),
		.s2_o(s2)
	);

	// Normalize, saturate, pack
	fp_multiplier_stage3 stage3 (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.s2_i(s2),
		.res_valid_o(res_valid_o),
		.res_o(res_o)
	);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock source
// Free-running clock with a 100 ns period that starts low
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o
);

	// Half period of 50 ns
	initial
	begin
		clk_o = 1'b0;
		forever
			#50 clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* verification/fp_multiplier_checker.sv */
// Protocol and result assertions for the floating-point multiplier
// Bound into every fp_multiplier instance
`timescale 1ns/1ps
`default_nettype none

module fp_multiplier_checker
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n_i,
	input wire fmul_req_t req_i,
	input wire logic res_valid_i,
	input wire float_t res_i
);

	// Number of failed assertions
	int fail_count = 0;

	logic zero_fmul;

	// FMUL request with at least one zero operand
	assign zero_fmul = req_i.valid && (req_i.op == FMUL_OP_FMUL) &&
		((req_i.a[30:0] == '0) || (req_i.b[30:0] == '0));

	// One result for each request after a fixed latency
	assert property (@(posedge clk) disable iff (!arst_n_i)
		res_valid_i == $past(req_i.valid, 3))
	else
	begin
		fail_count++;
		$error("result valid does not follow request valid by three cycles");
	end

	// Nothing comes out while in reset
	assert property (@(posedge clk) !arst_n_i |-> !res_valid_i)
	else
	begin
		fail_count++;
		$error("result valid high during reset");
	end

	// Saturated exponent only as infinity
	assert property (@(posedge clk) disable iff (!arst_n_i)
		(res_valid_i && (res_i.exponent == 8'hff)) |-> (res_i.fraction == '0))
	else
	begin
		fail_count++;
		$error("exponent 255 with a non-zero fraction");
	end

	// Zero operand gives zero magnitude
	assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(zero_fmul, 3) |-> (res_valid_i && (res_i[30:0] == '0)))
	else
	begin
		fail_count++;
		$error("zero operand did not give a zero result");
	end

endmodule

bind fp_multiplier fp_multiplier_checker check0 (
	.clk(clk),
	.arst_n_i(arst_n_i),
	.req_i(req_i),
	.res_valid_i(res_valid_o),
	.res_i(res_o)
);

`default_nettype wire

/* verification/fp_multiplier_tb.sv */
// Testbench for the pipelined floating-point multiplier
// Directed and LFSR-driven requests, scoreboard queue checked
// against a reference model of the arithmetic rule
`timescale 1ns/1ps
`default_nettype none

`include "fp_defines.svh"

module fp_multiplier_tb
	import fp_format_pkg::*;
	import fmul_pipe_pkg::*;
();

	logic clk;
	logic arst_n_i;
	fmul_req_t req;
	logic res_valid;
	float_t res;

	// Scoreboard of expected word, test name and issue cycle
	word_t exp_q[$];
	string name_q[$];
	int cyc_q[$];

	int cycle_cnt = 0;
	int errors = 0;
	int total_errors;
	logic [31:0] lfsr_state = 32'h701b2d70;

	tb_clock_gen clk_gen0 (
		.clk_o(clk)
	);

	fp_multiplier dut0 (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.req_i(req),
		.res_valid_o(res_valid),
		.res_o(res)
	);

	// Count of rising edges seen so far
	always_ff @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit with the new bit shifted in at the bottom
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Reference model of the multiply and convert rule
	function automatic word_t expected_result(input fmul_op_e op, input word_t a,
		input word_t b);
		logic sign;
		int exp_sum;
		logic [63:0] prod;
		logic [63:0] shifted;
		int p;
		int res_exp;
		logic found;
		if (op == FMUL_OP_ITOF)
		begin
			sign = a[31];
			if (a == '0)
				return '0;
			// Integer magnitude at weight one
			prod = {32'b0, (a[31] ? (32'd0 - a) : a)};
			exp_sum = 127 + 46;
		end
		else
		begin
			sign = a[31] ^ b[31];
			if ((a[30:0] == '0) || (b[30:0] == '0))
				return {sign, 31'b0};
			exp_sum = int'(a[30:23]) + int'(b[30:23]) - 127;
			prod = 64'({1'b1, a[22:0]}) * 64'({1'b1, b[22:0]});
		end
		// Leading one searched from the top
		p = 0;
		found = 1'b0;
		for (int i = 63; i >= 0; i--)
		begin
			if (!found && prod[i])
			begin
				p = i;
				found = 1'b1;
			end
		end
		res_exp = exp_sum + p - 46;
		if (res_exp >= 255)
			return {sign, 8'hff, 23'b0};
		if (res_exp <= 0)
			return {sign, 31'b0};
		// Fraction just below the leading one with low bits truncated
		if (p >= 23)
			shifted = prod >> (p - 23);
		else
			shifted = prod << (23 - p);
		return {sign, res_exp[7:0], shifted[22:0]};
	endfunction

	// Drive one request at the next rising edge and log what it should give
	task automatic issue(input fmul_op_e op, input word_t a, input word_t b,
		input string name);
		@(posedge clk);
		req.valid <= 1'b1;
		req.op <= op;
		req.a <= a;
		req.b <= b;
		exp_q.push_back(expected_result(op, a, b));
		name_q.push_back(name);
		cyc_q.push_back(cycle_cnt + 1);
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			req.valid <= 1'b0;
		end
	endtask

	// Normal float with the exponent kept in 1..254
	task automatic random_float(output word_t w);
		logic [31:0] s;
		logic [31:0] e;
		logic [31:0] f;
		take_bits(1, s);
		take_bits(8, e);
		take_bits(23, f);
		if (e[7:0] == 8'h00)
			e = 32'd1;
		if (e[7:0] == 8'hff)
			e = 32'd254;
		w = {s[0], e[7:0], f[22:0]};
	endtask

	// Wait until every pending operation has come out
	task automatic wait_drain(input int limit);
		for (int i = 0; (i < limit) && (exp_q.size() != 0); i++)
			@(posedge clk);
		if (exp_q.size() != 0)
		begin
			$display("%0d operations still pending after the drain timeout", exp_q.size());
			errors++;
		end
	endtask

	// Compare on the falling edge where the outputs are settled
	always
	begin
		word_t exp_word;
		string name;
		int cyc;
		@(negedge clk);
		if (res_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("result valid with no pending operation at cycle %0d", cycle_cnt);
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				name = name_q.pop_front();
				cyc = cyc_q.pop_front();
				if (res !== exp_word)
				begin
					$display("mismatch %s: expected %h, actual %h", name, exp_word, res);
					errors++;
				end
				if (cycle_cnt - cyc != `FMUL_LATENCY)
				begin
					$display("mismatch %s latency: expected %0d, actual %0d", name,
						`FMUL_LATENCY, cycle_cnt - cyc);
					errors++;
				end
			end
		end
	end

	initial
	begin
		fmul_op_e op;
		word_t a;
		word_t b;
		logic [31:0] r;
		arst_n_i = 1'b0;
		req.valid = 1'b0;
		req.op = FMUL_OP_FMUL;
		req.a = '0;
		req.b = '0;
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		// Quiet pipeline after reset
		idle(5);

		// Normal products, sign, binade carry, truncation
		issue(FMUL_OP_FMUL, 32'h3fc00000, 32'h40000000, "1.5 x 2.0");
		issue(FMUL_OP_FMUL, 32'hc0200000, 32'h40400000, "-2.5 x 3.0");
		issue(FMUL_OP_FMUL, 32'h3fe00000, 32'h3fe00000, "1.75 x 1.75 carry");
		issue(FMUL_OP_FMUL, 32'h3faaaaab, 32'h3faaaaab, "truncation 1.333");
		issue(FMUL_OP_FMUL, 32'h3f7fffff, 32'h3f7fffff, "truncation below one");
		// Zero operands give the XOR sign
		issue(FMUL_OP_FMUL, 32'h00000000, 32'h40000000, "zero x 2.0");
		issue(FMUL_OP_FMUL, 32'h80000000, 32'h40000000, "-zero x 2.0");
		issue(FMUL_OP_FMUL, 32'hc0000000, 32'h80000000, "-2.0 x -zero");
		issue(FMUL_OP_FMUL, 32'h00000000, 32'h80000000, "zero x -zero");
		// Exponent saturation
		issue(FMUL_OP_FMUL, 32'h7f000000, 32'h7f000000, "overflow");
		issue(FMUL_OP_FMUL, 32'hff000000, 32'h7f000000, "negative overflow");
		issue(FMUL_OP_FMUL, 32'h7f000000, 32'h40000000, "exponent 255");
		issue(FMUL_OP_FMUL, 32'h00800000, 32'h00800000, "underflow");
		issue(FMUL_OP_FMUL, 32'h80800000, 32'h00800000, "negative underflow");
		// Integer conversion
		issue(FMUL_OP_ITOF, 32'h00000000, '0, "itof 0");
		issue(FMUL_OP_ITOF, 32'h00000001, '0, "itof 1");
		issue(FMUL_OP_ITOF, 32'hffffffff, '0, "itof -1");
		issue(FMUL_OP_ITOF, 32'h80000000, '0, "itof -2^31");
		issue(FMUL_OP_ITOF, 32'h01000001, '0, "itof 2^24+1");
		issue(FMUL_OP_ITOF, 32'h7fffffff, '0, "itof max");
		issue(FMUL_OP_ITOF, 32'hf8a432eb, '0, "itof -123456789");
		idle(1);
		wait_drain(20);

		// Mixed random traffic with occasional idle gaps
		for (int i = 0; i < 400; i++)
		begin
			take_bits(2, r);
			op = (r[1:0] == 2'd0) ? FMUL_OP_ITOF : FMUL_OP_FMUL;
			if (op == FMUL_OP_ITOF)
			begin
				take_bits(32, a);
				b = '0;
			end
			else
			begin
				random_float(a);
				random_float(b);
			end
			issue(op, a, b, $sformatf("random %0d", i));
			take_bits(2, r);
			if (r[1:0] == 2'd0)
			begin
				take_bits(2, r);
				idle(int'(r[1:0]) + 1);
			end
		end
		idle(1);
		wait_drain(20);

		total_errors = errors + dut0.check0.fail_count;
		$display("errors: %0d (scoreboard %0d, assertions %0d)", total_errors, errors,
			dut0.check0.fail_count);
		if (total_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/fp_format_pkg.sv
source/fmul_pipe_pkg.sv
source/fp_multiplier_stage1.sv
source/fp_multiplier_stage2.sv
source/fp_multiplier_stage3.sv
source/fp_multiplier.sv
verification/tb_clock_gen.sv
verification/fp_multiplier_checker.sv
verification/fp_multiplier_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the floating-point multiplier testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f src.f \
	--top-module fp_multiplier_tb \
	--Mdir "$BUILD_DIR" \
	-o fp_multiplier_sim

"./$BUILD_DIR/fp_multiplier_sim" +verilator+error+limit+100 | tee "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"
then
	echo "simulation failed"
	exit 1
fi

echo "simulation finished without failure"
